/* hw/spk_cfg_pkg.sv */
package spk_cfg_pkg;

  // recording geometry
  localparam int NUM_CH   = 32;
  localparam int CH_W     = 5;
  localparam int SAMPLE_W = 16;

  // host register map
  // thresholds sit at 0..NUM_CH-1, control word right after them
  localparam int REG_ADDR_W = 6;
  localparam int CTRL_ADDR  = NUM_CH;

  // host side word width
  localparam int HOST_W = 32;

  // frame number carried in spike events
  localparam int FRAME_W = 32;

  // FIFO sizes
  // mua depth in words, info depth in 64-bit events
  localparam int MUA_DEPTH  = 16;
  localparam int INFO_DEPTH = 8;

endpackage

/* hw/spk_word_pkg.sv */
package spk_word_pkg;

  import spk_cfg_pkg::*;

  // field widths inside the mua word
  localparam int MUA_CH_W    = 8;
  localparam int MUA_FRAME_W = 7;

  // mua word as seen by the host
  // raw view for the FIFO, field view for building and decoding
  typedef union packed {
    logic [HOST_W-1:0] raw;
    struct packed {
      logic signed [SAMPLE_W-1:0] sample;
      logic [MUA_CH_W-1:0]        ch;
      logic [MUA_FRAME_W-1:0]     frame_lo;
      logic                       peak;
    } f;
  } muap_word_t;

  // spike event, frame in the low host word and channel in the high one
  localparam int INFO_W     = 64;
  localparam int INFO_WORDS = 2;
  localparam int INFO_SEL_W = $clog2(INFO_WORDS);

endpackage

/* hw/thr_bank.sv */
module thr_bank import spk_cfg_pkg::*; (
  input  logic                       bus_clk,
  input  logic                       rst_n,
  input  logic                       reg_wren,
  input  logic                       reg_rden,
  input  logic [REG_ADDR_W-1:0]      reg_addr,
  input  logic [HOST_W-1:0]          reg_wdata,
  input  logic [CH_W-1:0]            lk_ch,
  output logic [HOST_W-1:0]          reg_rdata,
  output logic signed [SAMPLE_W-1:0] lk_thr,
  output logic                       det_en
);

  logic signed [SAMPLE_W-1:0] thr_mem [NUM_CH];
  logic [HOST_W-1:0]          ctrl_reg;
  logic                       addr_is_thr;
  logic                       addr_is_ctrl;
  logic signed [SAMPLE_W-1:0] rd_thr;

  assign addr_is_thr  = reg_addr < REG_ADDR_W'(NUM_CH);
  assign addr_is_ctrl = reg_addr == REG_ADDR_W'(CTRL_ADDR);
  assign rd_thr       = thr_mem[reg_addr[CH_W-1:0]];

  // host writes, out of range addresses fall through untouched
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CH; i++) begin
        thr_mem[i] <= '0;
      end
      ctrl_reg <= '0;
    end else if (reg_wren) begin
      if (addr_is_thr) begin
        thr_mem[reg_addr[CH_W-1:0]] <= reg_wdata[SAMPLE_W-1:0];
      end else if (addr_is_ctrl) begin
        ctrl_reg <= reg_wdata;
      end
    end
  end

  // host read-back, one cycle after rden
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else if (reg_rden) begin
      if (addr_is_thr) begin
        reg_rdata <= {{(HOST_W-SAMPLE_W){rd_thr[SAMPLE_W-1]}}, rd_thr};
      end else if (addr_is_ctrl) begin
        reg_rdata <= ctrl_reg;
      end else begin
        reg_rdata <= '0;
      end
    end
  end

  // detector lookup, enable travels with the threshold
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      lk_thr <= '0;
      det_en <= 1'b0;
    end else begin
      lk_thr <= thr_mem[lk_ch];
      det_en <= ctrl_reg[0];
    end
  end

  // host side drives one access per cycle
  a_no_rd_wr_overlap: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    !(reg_rden && reg_wren)
  );

endmodule

/* hw/spk_det.sv */
module spk_det import spk_cfg_pkg::*, spk_word_pkg::*; (
  input  logic                       bus_clk,
  input  logic                       rst_n,
  input  logic                       acq_run,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  logic [CH_W-1:0]            s_ch,
  input  logic signed [SAMPLE_W-1:0] s_data,
  output logic [CH_W-1:0]            lk_ch,
  input  logic signed [SAMPLE_W-1:0] lk_thr,
  input  logic                       det_en,
  output logic                       mua_valid,
  input  logic                       mua_ready,
  output muap_word_t                 mua_word,
  output logic                       info_push,
  output logic [INFO_W-1:0]          info_event
);

  logic                       s1_valid;
  logic [CH_W-1:0]            s1_ch;
  logic signed [SAMPLE_W-1:0] s1_data;
  logic                       s2_valid;
  muap_word_t                 s2_word;
  muap_word_t                 s2_next;
  logic [INFO_W-1:0]          s2_event;
  logic [FRAME_W-1:0]         frame_cnt;
  logic [FRAME_W-1:0]         frame_cur;
  logic                       s2_ready;
  logic                       s2_load;
  logic                       s_fire;
  logic                       is_peak;

  assign s2_ready = !s2_valid || mua_ready;
  assign s_ready  = !s1_valid || s2_ready;
  assign s_fire   = s_valid && s_ready;
  assign s2_load  = s1_valid && s2_ready;

  // look up the incoming channel, or re-read the held one on a stall
  // so lk_thr keeps matching stage 1
  assign lk_ch = s_ready ? s_ch : s1_ch;

  assign frame_cur = acq_run ? frame_cnt : '0;
  assign is_peak   = det_en && (s1_data < lk_thr);

  always_comb begin
    s2_next.f.sample   = s1_data;
    s2_next.f.ch       = MUA_CH_W'(s1_ch);
    s2_next.f.frame_lo = frame_cur[MUA_FRAME_W-1:0];
    s2_next.f.peak     = is_peak;
  end

  // stage 1
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (s_ready) begin
      s1_valid <= s_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s_fire) begin
      s1_ch   <= s_ch;
      s1_data <= s_data;
    end
  end

  // stage 2, holds its word while the mua FIFO is full
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s2_load) begin
      s2_word  <= s2_next;
      s2_event <= {HOST_W'(s1_ch), frame_cur};
    end
  end

  // frame count steps as the last channel hands off into stage 2
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (!acq_run) begin
      frame_cnt <= '0;
    end else if (s2_load && s1_ch == CH_W'(NUM_CH - 1)) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  assign mua_valid  = s2_valid;
  assign mua_word   = s2_word;
  assign info_event = s2_event;
  // event leaves together with the mua write of its peak word
  assign info_push  = s2_valid && mua_ready && s2_word.f.peak;

  // upstream keeps a stalled sample steady until it is taken
  a_s_hold: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    (s_valid && !s_ready) |=> (s_valid && $stable(s_ch) && $stable(s_data))
  );

  a_mua_hold: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    (mua_valid && !mua_ready) |=> (mua_valid && $stable(mua_word))
  );

endmodule

/* hw/host_fifo.sv */
module host_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             bus_clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr_ok;
  logic             rd_ok;

  assign full  = count == (PTR_W+1)'(DEPTH);
  assign empty = count == '0;
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  // first word fall through, head is always on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    count <= (PTR_W+1)'(DEPTH)
  );

endmodule

/* hw/spk_info_fifo.sv */
module spk_info_fifo import spk_cfg_pkg::*, spk_word_pkg::*; (
  input  logic              bus_clk,
  input  logic              rst_n,
  input  logic              info_push,
  input  logic [INFO_W-1:0] info_event,
  input  logic              info_rden,
  output logic [HOST_W-1:0] info_rdata,
  output logic              info_empty,
  output logic              info_overflow
);

  logic [INFO_W-1:0]     fifo_dout;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  fifo_wr;
  logic                  fifo_rd;
  logic                  rd_ok;
  logic                  last_half;
  logic [INFO_SEL_W-1:0] half_sel;

  // no back-pressure here, a push into a full FIFO is lost
  assign fifo_wr = info_push && !fifo_full;

  assign rd_ok     = info_rden && !fifo_empty;
  assign last_half = half_sel == INFO_SEL_W'(INFO_WORDS - 1);
  // pop only once the channel word has gone out
  assign fifo_rd   = rd_ok && last_half;

  // frame word first, then channel word
  assign info_rdata = fifo_dout[half_sel*HOST_W +: HOST_W];
  assign info_empty = fifo_empty;

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      half_sel <= '0;
    end else if (rd_ok) begin
      half_sel <= last_half ? '0 : half_sel + 1'b1;
    end
  end

  // sticky until reset
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      info_overflow <= 1'b0;
    end else if (info_push && fifo_full) begin
      info_overflow <= 1'b1;
    end
  end

  host_fifo #(
    .WIDTH (INFO_W),
    .DEPTH (INFO_DEPTH)
  ) event_fifo_inst (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .wr_en   (fifo_wr),
    .din     (info_event),
    .rd_en   (fifo_rd),
    .dout    (fifo_dout),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

endmodule

/* hw/spk_sort_top.sv */
module spk_sort_top import spk_cfg_pkg::*, spk_word_pkg::*; (
  input  logic                       bus_clk,
  input  logic                       rst_n,
  input  logic                       acq_run,
  input  logic                       reg_wren,
  input  logic                       reg_rden,
  input  logic [REG_ADDR_W-1:0]      reg_addr,
  input  logic [HOST_W-1:0]          reg_wdata,
  output logic [HOST_W-1:0]          reg_rdata,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  logic [CH_W-1:0]            s_ch,
  input  logic signed [SAMPLE_W-1:0] s_data,
  input  logic                       mua_rden,
  output logic                       mua_empty,
  output logic [HOST_W-1:0]          mua_rdata,
  input  logic                       info_rden,
  output logic                       info_empty,
  output logic [HOST_W-1:0]          info_rdata,
  output logic                       info_overflow
);

  logic [CH_W-1:0]            lk_ch;
  logic signed [SAMPLE_W-1:0] lk_thr;
  logic                       det_en;
  logic                       mua_valid;
  logic                       mua_full;
  muap_word_t                 mua_word;
  logic                       info_push;
  logic [INFO_W-1:0]          info_event;

  thr_bank thr_bank_inst (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .reg_wren  (reg_wren),
    .reg_rden  (reg_rden),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .lk_ch     (lk_ch),
    .reg_rdata (reg_rdata),
    .lk_thr    (lk_thr),
    .det_en    (det_en)
  );

  spk_det spk_det_inst (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .acq_run    (acq_run),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_ch       (s_ch),
    .s_data     (s_data),
    .lk_ch      (lk_ch),
    .lk_thr     (lk_thr),
    .det_en     (det_en),
    .mua_valid  (mua_valid),
    .mua_ready  (!mua_full),
    .mua_word   (mua_word),
    .info_push  (info_push),
    .info_event (info_event)
  );

  // mua stream to host, full flag is the back-pressure
  host_fifo #(
    .WIDTH (HOST_W),
    .DEPTH (MUA_DEPTH)
  ) mua_fifo_inst (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .wr_en   (mua_valid),
    .din     (mua_word.raw),
    .rd_en   (mua_rden),
    .dout    (mua_rdata),
    .full    (mua_full),
    .empty   (mua_empty)
  );

  spk_info_fifo spk_info_fifo_inst (
    .bus_clk       (bus_clk),
    .rst_n         (rst_n),
    .info_push     (info_push),
    .info_event    (info_event),
    .info_rden     (info_rden),
    .info_rdata    (info_rdata),
    .info_empty    (info_empty),
    .info_overflow (info_overflow)
  );

endmodule

/* testbench/tb_spk_sort.sv */
module tb_spk_sort import spk_cfg_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 2000;

  logic                       bus_clk;
  logic                       rst_n;
  logic                       acq_run;
  logic                       reg_wren;
  logic                       reg_rden;
  logic [REG_ADDR_W-1:0]      reg_addr;
  logic [HOST_W-1:0]          reg_wdata;
  logic [HOST_W-1:0]          reg_rdata;
  logic                       s_valid;
  logic                       s_ready;
  logic [CH_W-1:0]            s_ch;
  logic signed [SAMPLE_W-1:0] s_data;
  logic                       mua_rden;
  logic                       mua_empty;
  logic [HOST_W-1:0]          mua_rdata;
  logic                       info_rden;
  logic                       info_empty;
  logic [HOST_W-1:0]          info_rdata;
  logic                       info_overflow;

  // reference model state
  logic signed [SAMPLE_W-1:0] model_thr [NUM_CH];
  logic                       model_en;
  logic [FRAME_W-1:0]         model_frame;
  logic [HOST_W-1:0]          exp_mua [$];
  logic [HOST_W-1:0]          exp_info [$];
  bit                         mua_rd_on;
  bit                         info_rd_on;
  bit                         info_paused;
  int                         paused_cnt;
  integer                     seed;

  spk_sort_top spk_sort_top_inst (
    .bus_clk       (bus_clk),
    .rst_n         (rst_n),
    .acq_run       (acq_run),
    .reg_wren      (reg_wren),
    .reg_rden      (reg_rden),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_ch          (s_ch),
    .s_data        (s_data),
    .mua_rden      (mua_rden),
    .mua_empty     (mua_empty),
    .mua_rdata     (mua_rdata),
    .info_rden     (info_rden),
    .info_empty    (info_empty),
    .info_rdata    (info_rdata),
    .info_overflow (info_overflow)
  );

  initial begin
    bus_clk = 1'b0;
    forever #20 bus_clk = ~bus_clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // every drive happens 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge bus_clk);
    #2;
  endtask

  task automatic reg_write(input int addr, input logic [HOST_W-1:0] data);
    reg_wren  = 1'b1;
    reg_addr  = REG_ADDR_W'(addr);
    reg_wdata = data;
    step_cycle();
    reg_wren  = 1'b0;
  endtask

  task automatic reg_read_check(input int addr, input logic [HOST_W-1:0] expected);
    reg_rden = 1'b1;
    reg_addr = REG_ADDR_W'(addr);
    step_cycle();
    reg_rden = 1'b0;
    assert (reg_rdata == expected) else
      fail_now($sformatf("** Error reg_rdata at %0d: got %h, expected %h",
                         addr, reg_rdata, expected));
  endtask

  task automatic set_ctrl(input logic en);
    logic [HOST_W-1:0] ctrl;
    ctrl    = $random(seed);
    ctrl[0] = en;
    reg_write(CTRL_ADDR, ctrl);
    model_en = en;
    step_cycle();
    reg_read_check(CTRL_ADDR, ctrl);
  endtask

  task automatic set_acq(input logic run);
    acq_run = run;
    if (!run) begin
      model_frame = '0;
    end
    step_cycle();
  endtask

  // expected mua word and spike event for one accepted sample
  task automatic model_accept(input logic [CH_W-1:0] ch, input logic signed [SAMPLE_W-1:0] data);
    logic               peak;
    logic [FRAME_W-1:0] frame;
    peak  = model_en && (data < model_thr[ch]);
    frame = acq_run ? model_frame : '0;
    // sample, zero-extended channel, frame low bits, peak
    exp_mua.push_back({data, 3'b000, ch, frame[6:0], peak});
    if (peak) begin
      if (!info_paused || paused_cnt < INFO_DEPTH) begin
        exp_info.push_back(frame);
        exp_info.push_back(HOST_W'(ch));
      end
      if (info_paused) begin
        paused_cnt++;
      end
    end
    if (acq_run && ch == CH_W'(NUM_CH - 1)) begin
      model_frame = model_frame + 1;
    end
  endtask

  task automatic send_sample(input logic [CH_W-1:0] ch, input logic signed [SAMPLE_W-1:0] data);
    int waited;
    waited  = 0;
    s_valid = 1'b1;
    s_ch    = ch;
    s_data  = data;
    // s_ready is registered state, stable until the next edge
    while (!s_ready) begin
      step_cycle();
      waited++;
      assert (waited < WAIT_LIMIT) else fail_now("sample stream stalled, s_ready never returned");
    end
    model_accept(ch, data);
    step_cycle();
    s_valid = 1'b0;
  endtask

  task automatic send_random(input int n);
    logic [CH_W-1:0]            ch;
    logic signed [SAMPLE_W-1:0] data;
    for (int i = 0; i < n; i++) begin
      ch   = CH_W'($random(seed));
      data = SAMPLE_W'($random(seed));
      if (($random(seed) & 3) == 0) begin
        step_cycle();
      end
      send_sample(ch, data);
    end
  endtask

  task automatic send_frames(input int n);
    for (int f = 0; f < n; f++) begin
      for (int c = 0; c < NUM_CH; c++) begin
        send_sample(CH_W'(c), SAMPLE_W'($random(seed)));
      end
    end
  endtask

  // wait until the readers have consumed every expected word
  task automatic drain(input bit with_info);
    int waited;
    waited = 0;
    while (exp_mua.size() != 0 || (with_info && exp_info.size() != 0)) begin
      step_cycle();
      waited++;
      assert (waited < WAIT_LIMIT) else fail_now("timed out waiting for the host FIFOs to drain");
    end
    repeat (3) step_cycle();
    assert (mua_empty && (!with_info || info_empty)) else
      fail_now("a host FIFO still holds data after all expected words were read");
  endtask

  // host reader for the mua FIFO, about every other cycle
  initial begin
    mua_rden = 1'b0;
    forever begin
      step_cycle();
      mua_rden = 1'b0;
      if (mua_rd_on && !mua_empty && (($random(seed) & 1) != 0)) begin
        assert (exp_mua.size() > 0) else fail_now("MUA FIFO returned a word that was never sent");
        assert (mua_rdata == exp_mua[0]) else
          fail_now($sformatf("** Error mua_rdata: got %h, expected %h", mua_rdata, exp_mua[0]));
        void'(exp_mua.pop_front());
        mua_rden = 1'b1;
      end
    end
  end

  // host reader for the spike-info FIFO, frame word then channel word
  initial begin
    info_rden = 1'b0;
    forever begin
      step_cycle();
      info_rden = 1'b0;
      if (info_rd_on && !info_empty && (($random(seed) & 7) != 0)) begin
        assert (exp_info.size() > 0) else fail_now("spike-info FIFO returned an unexpected event");
        assert (info_rdata == exp_info[0]) else
          fail_now($sformatf("** Error info_rdata: got %h, expected %h", info_rdata, exp_info[0]));
        void'(exp_info.pop_front());
        info_rden = 1'b1;
      end
    end
  end

  initial begin
    logic [HOST_W-1:0]          wdata;
    logic signed [SAMPLE_W-1:0] neg_data;
    int                         addr;
    seed        = 86;
    rst_n       = 1'b0;
    acq_run     = 1'b0;
    reg_wren    = 1'b0;
    reg_rden    = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    s_valid     = 1'b0;
    s_ch        = '0;
    s_data      = '0;
    mua_rd_on   = 1'b0;
    info_rd_on  = 1'b0;
    info_paused = 1'b0;
    paused_cnt  = 0;
    model_en    = 1'b0;
    model_frame = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      model_thr[i] = '0;
    end
    repeat (2) @(posedge bus_clk);
    #2;
    rst_n = 1'b1;
    step_cycle();
    assert (s_ready && mua_empty && info_empty && !info_overflow) else
      fail_now("outputs are not in their reset state after reset");

    // register access, the out of range write must not land anywhere
    for (int i = 0; i < NUM_CH; i++) begin
      wdata = $random(seed);
      reg_write(i, wdata);
      model_thr[i] = wdata[SAMPLE_W-1:0];
    end
    reg_write(CTRL_ADDR + 5, 32'hffff_ffff);
    set_ctrl(1'b0);
    // signed threshold widened to the host word
    for (int i = 0; i < NUM_CH; i++) begin
      reg_read_check(i, HOST_W'(model_thr[i]));
    end
    for (int i = 0; i < 8; i++) begin
      addr = CTRL_ADDR + 1 + (($random(seed) & 32'h7fff_ffff) % (2**REG_ADDR_W - CTRL_ADDR - 1));
      reg_read_check(addr, '0);
    end

    mua_rd_on  = 1'b1;
    info_rd_on = 1'b1;
    set_acq(1'b1);

    // detection off, no events expected
    send_random(64);
    drain(1'b1);

    // detection on, random channels then ordered frames
    set_ctrl(1'b1);
    send_random(200);
    send_frames(3);
    drain(1'b1);

    // frame number held at zero while acquisition is stopped
    set_acq(1'b0);
    send_random(40);
    send_frames(1);
    drain(1'b1);
    set_acq(1'b1);
    send_frames(2);
    drain(1'b1);

    // mua back-pressure with detection off
    set_ctrl(1'b0);
    mua_rd_on = 1'b0;
    fork
      send_random(MUA_DEPTH + 8);
      begin : stall_watch
        int waited;
        waited = 0;
        while (s_ready) begin
          step_cycle();
          waited++;
          assert (waited < WAIT_LIMIT) else fail_now("s_ready never fell with MUA reads paused");
        end
        repeat (8) step_cycle();
        mua_rd_on = 1'b1;
      end
    join
    drain(1'b1);

    // spike-info overflow, every sample on channel 5 is a peak
    assert (!info_overflow) else fail_now("spike-info overflow flag rose before the overflow test");
    reg_write(5, 32'h0000_7fff);
    model_thr[5] = 16'sh7fff;
    set_ctrl(1'b1);
    info_rd_on  = 1'b0;
    info_paused = 1'b1;
    paused_cnt  = 0;
    for (int i = 0; i < INFO_DEPTH + 4; i++) begin
      neg_data              = SAMPLE_W'($random(seed));
      neg_data[SAMPLE_W-1]  = 1'b1;
      send_sample(CH_W'(5), neg_data);
    end
    drain(1'b0);
    assert (info_overflow) else fail_now("overflow flag did not rise after the spike-info FIFO filled");
    info_paused = 1'b0;
    info_rd_on  = 1'b1;
    drain(1'b1);
    assert (info_overflow) else fail_now("overflow flag did not stay set after readout");

    $display("TB PASSED");
    $finish;
  end

endmodule

/* filelist.f */
hw/spk_cfg_pkg.sv
hw/spk_word_pkg.sv
hw/thr_bank.sv
hw/spk_det.sv
hw/host_fifo.sv
hw/spk_info_fifo.sv
hw/spk_sort_top.sv
testbench/tb_spk_sort.sv

/* Makefile */
# Verilator build for the spike-detection back end
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_spk_sort
RTL_TOP   ?= spk_sort_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TB PASSED

RTL_SRCS := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# the log decides the result, not the simulator exit code
sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
